// ==== pkt_cfg.svh ====
`ifndef PKT_CFG_SVH
`define PKT_CFG_SVH

// Packet type codes from the host.
`define BAG_DLINK 4'h8
`define BAG_DTYPE 4'h9
`define BAG_DTEMP 4'hA
`define BAG_DATA0 4'hD
`define BAG_DATA1 4'hE

// Header nibbles, high half of the first frame byte.
`define HEAD_DLINK 4'hD
`define HEAD_DTYPE 4'h1
`define HEAD_DTEMP 4'h9
`define HEAD_DATA  4'h3

`define DLINK_WORD 12'h123

`define CHIP_NUM   8
`define DATA_LEN   64
`define RAM_AW     12
`define FIFO_DEPTH 128

`endif

// ==== pkt_pkg.sv ====
`include "pkt_cfg.svh"

package pkt_pkg;

    typedef logic [7:0] adc_sample_t;

    typedef struct packed {
        logic [3:0] device_idx;
        logic [3:0] data_idx;
    } dev_cmd_t;

    typedef struct packed {
        logic [7:0] temp;
        logic [7:0] dev_type;
        logic [3:0] stat;
    } dev_stat_t;

    typedef struct packed {
        logic               en;
        logic [`RAM_AW-1:0] addr;
        logic [7:0]         data;
    } ram_wr_t;

    typedef enum logic [3:0] {
        ST_WAIT, ST_IGNORE,
        ST_LINK_HI, ST_LINK_LO, ST_TYPE_HI, ST_TYPE_LO, ST_TEMP_HI, ST_TEMP_LO,
        ST_DATA_HEAD, ST_DATA_STAT, ST_DATA_GAP, ST_DATA_COPY,
        ST_FLUSH, ST_DONE
    } build_state_t;

endpackage

// ==== sample_fifo.sv ====
`timescale 1ns/1ps
`include "pkt_cfg.svh"

module sample_fifo
    import pkt_pkg::*;
#(
    parameter type payload_t = adc_sample_t
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     wr,
    input  payload_t din,
    input  logic     rd,
    output payload_t dout,
    output logic     empty,
    output logic     full
);

    localparam int unsigned AW = $clog2(`FIFO_DEPTH);
    localparam logic [AW:0] DEPTH = (AW + 1)'(`FIFO_DEPTH);

    payload_t        mem [`FIFO_DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [AW:0]     count;

    // Head entry is always on the output.
    assign dout  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == DEPTH);

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr) wr_ptr <= wr_ptr + 1'b1;
            if (rd) rd_ptr <= rd_ptr + 1'b1;
            case ({wr, rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst) wr |-> !full)
        else $error("sample_fifo: write while full");
    a_no_underflow: assert property (@(posedge clk) disable iff (rst) rd |-> !empty)
        else $error("sample_fifo: read while empty");

endmodule

// ==== frame_builder.sv ====
`timescale 1ns/1ps
`include "pkt_cfg.svh"

module frame_builder
    import pkt_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fs,
    input  logic [3:0]           btype,
    input  logic [`RAM_AW-1:0]   frame_base,
    input  dev_cmd_t             cmd,
    input  dev_stat_t            stat,
    input  adc_sample_t          fifo_dout [`CHIP_NUM],
    input  logic [`CHIP_NUM-1:0] fifo_empty,
    output logic                 fd,
    output logic [`CHIP_NUM-1:0] fifo_rd,
    output ram_wr_t              wr
);

    localparam int unsigned SAMPLE_W = $clog2(`DATA_LEN);
    localparam int unsigned CHIP_W = $clog2(`CHIP_NUM);
    localparam logic [SAMPLE_W-1:0] LAST_SAMPLE = SAMPLE_W'(`DATA_LEN - 1);
    localparam logic [CHIP_W-1:0] LAST_CHIP = CHIP_W'(`CHIP_NUM - 1);
    localparam logic [11:0] LINK_WORD = `DLINK_WORD;

    build_state_t          state;
    build_state_t          state_next;
    logic [SAMPLE_W-1:0]   sample_cnt;
    logic [CHIP_W-1:0]     chip_idx;
    logic [`CHIP_NUM-1:0]  chip_sel;
    adc_sample_t           sample_mux;
    logic                  block_end;
    ram_wr_t               wr_next;

    assign block_end  = (sample_cnt == LAST_SAMPLE);
    assign chip_sel   = `CHIP_NUM'(1) << chip_idx;
    assign sample_mux = fifo_dout[chip_idx];
    assign fifo_rd    = (state == ST_DATA_COPY) ? chip_sel : '0;
    assign fd         = (state == ST_DONE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_WAIT;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_WAIT: begin
                if (fs) begin
                    case (btype)
                        `BAG_DLINK:             state_next = ST_LINK_HI;
                        `BAG_DTYPE:             state_next = ST_TYPE_HI;
                        `BAG_DTEMP:             state_next = ST_TEMP_HI;
                        `BAG_DATA0, `BAG_DATA1: state_next = ST_DATA_HEAD;
                        default:                state_next = ST_IGNORE;
                    endcase
                end
            end
            // Unknown code waits here until the host lets go.
            ST_IGNORE:    if (!fs) state_next = ST_WAIT;
            ST_LINK_HI:   state_next = ST_LINK_LO;
            ST_LINK_LO:   state_next = ST_FLUSH;
            ST_TYPE_HI:   state_next = ST_TYPE_LO;
            ST_TYPE_LO:   state_next = ST_FLUSH;
            ST_TEMP_HI:   state_next = ST_TEMP_LO;
            ST_TEMP_LO:   state_next = ST_FLUSH;
            ST_DATA_HEAD: state_next = ST_DATA_STAT;
            ST_DATA_STAT: state_next = ST_DATA_GAP;
            ST_DATA_GAP:  state_next = ST_DATA_COPY;
            ST_DATA_COPY: begin
                if (block_end) begin
                    state_next = (chip_idx == LAST_CHIP) ? ST_FLUSH : ST_DATA_GAP;
                end
            end
            // Last byte lands in the RAM here.
            ST_FLUSH:     state_next = ST_DONE;
            ST_DONE:      if (!fs) state_next = ST_WAIT;
            default:      state_next = ST_WAIT;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sample_cnt <= '0;
            chip_idx   <= '0;
        end else begin
            case (state)
                ST_DATA_HEAD: chip_idx <= '0;
                ST_DATA_GAP:  sample_cnt <= '0;
                ST_DATA_COPY: begin
                    sample_cnt <= sample_cnt + 1'b1;
                    if (block_end) chip_idx <= chip_idx + 1'b1;
                end
                default: ;
            endcase
        end
    end

    // Address moves only on a write and holds through gaps.
    always_comb begin
        wr_next = '{en: 1'b0, addr: wr.addr, data: wr.data};
        case (state)
            ST_LINK_HI: begin
                wr_next = '{en: 1'b1, addr: frame_base,
                            data: {`HEAD_DLINK, LINK_WORD[11:8]}};
            end
            ST_TYPE_HI: begin
                wr_next = '{en: 1'b1, addr: frame_base,
                            data: {`HEAD_DTYPE, cmd.device_idx}};
            end
            ST_TEMP_HI: begin
                wr_next = '{en: 1'b1, addr: frame_base,
                            data: {`HEAD_DTEMP, cmd.device_idx}};
            end
            ST_DATA_HEAD: begin
                wr_next = '{en: 1'b1, addr: frame_base,
                            data: {`HEAD_DATA, cmd.device_idx}};
            end
            ST_LINK_LO:   wr_next = '{en: 1'b1, addr: wr.addr + 1'b1, data: LINK_WORD[7:0]};
            ST_TYPE_LO:   wr_next = '{en: 1'b1, addr: wr.addr + 1'b1, data: stat.dev_type};
            ST_TEMP_LO:   wr_next = '{en: 1'b1, addr: wr.addr + 1'b1, data: stat.temp};
            ST_DATA_STAT: begin
                wr_next = '{en: 1'b1, addr: wr.addr + 1'b1,
                            data: {cmd.data_idx, stat.stat}};
            end
            ST_DATA_COPY: wr_next = '{en: 1'b1, addr: wr.addr + 1'b1, data: sample_mux};
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr <= '0;
        end else begin
            wr <= wr_next;
        end
    end

    a_no_write_when_done: assert property (
        @(posedge clk) disable iff (rst) fd |-> !wr.en)
        else $error("frame_builder: RAM write pending while fd is high");

    // Host must preload every FIFO before a data frame.
    a_no_empty_pop: assert property (
        @(posedge clk) disable iff (rst) !(|(fifo_rd & fifo_empty)))
        else $error("frame_builder: pop from an empty sample FIFO");

endmodule

// ==== frame_ram.sv ====
`timescale 1ns/1ps
`include "pkt_cfg.svh"

module frame_ram
    import pkt_pkg::*;
(
    input  logic               clk,
    input  ram_wr_t            wr,
    input  logic [`RAM_AW-1:0] rd_addr,
    output logic [7:0]         rd_data
);

    localparam int unsigned DEPTH = 2 ** `RAM_AW;

    logic [7:0] mem [DEPTH];

    // Builder side.
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Host side, one cycle of read latency.
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== acq_frame_top.sv ====
`timescale 1ns/1ps
`include "pkt_cfg.svh"

module acq_frame_top
    import pkt_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fs,
    input  logic [3:0]           btype,
    input  logic [`RAM_AW-1:0]   frame_base,
    input  dev_cmd_t             cmd,
    input  dev_stat_t            stat,
    input  logic [`CHIP_NUM-1:0] adc_wr,
    input  adc_sample_t          adc_din [`CHIP_NUM],
    input  logic [`RAM_AW-1:0]   rd_addr,
    output logic                 fd,
    output logic [7:0]           rd_data,
    output logic [`CHIP_NUM-1:0] fifo_full
);

    adc_sample_t          fifo_dout [`CHIP_NUM];
    logic [`CHIP_NUM-1:0] fifo_empty;
    logic [`CHIP_NUM-1:0] fifo_rd;
    ram_wr_t              wr;

    // One sample FIFO per ADC chip.
    for (genvar i = 0; i < `CHIP_NUM; i++) begin : g_chip
        sample_fifo #(
            .payload_t(adc_sample_t)
        ) u_fifo (
            .clk   (clk),
            .rst   (rst),
            .wr    (adc_wr[i]),
            .din   (adc_din[i]),
            .rd    (fifo_rd[i]),
            .dout  (fifo_dout[i]),
            .empty (fifo_empty[i]),
            .full  (fifo_full[i])
        );
    end

    frame_builder u_builder (
        .clk        (clk),
        .rst        (rst),
        .fs         (fs),
        .btype      (btype),
        .frame_base (frame_base),
        .cmd        (cmd),
        .stat       (stat),
        .fifo_dout  (fifo_dout),
        .fifo_empty (fifo_empty),
        .fd         (fd),
        .fifo_rd    (fifo_rd),
        .wr         (wr)
    );

    frame_ram u_ram (
        .clk     (clk),
        .wr      (wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);

    localparam real HALF_PERIOD = 5.0;
    localparam int RESET_CYCLES = 4;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Reset released just after an edge, like the other stimulus.
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

// ==== tb_acq_frame.sv ====
`timescale 1ns/1ps
`include "pkt_cfg.svh"

module tb_acq_frame
    import pkt_pkg::*;
();

    localparam int SHORT_LAT = 3;
    localparam int DATA_LAT = 3 + `CHIP_NUM * (`DATA_LEN + 1);
    // Each data test is about 1.1k cycles with preload and readback.
    // Short frames and the ignore test add under a hundred.
    localparam int TIMEOUT_CYCLES = 4000;

    logic                 clk;
    logic                 rst;
    logic                 fs;
    logic [3:0]           btype;
    logic [`RAM_AW-1:0]   frame_base;
    dev_cmd_t             cmd;
    dev_stat_t            stat;
    logic [`CHIP_NUM-1:0] adc_wr;
    adc_sample_t          adc_din [`CHIP_NUM];
    logic [`RAM_AW-1:0]   rd_addr;
    logic                 fd;
    logic [7:0]           rd_data;
    logic [`CHIP_NUM-1:0] fifo_full;

    adc_sample_t          samples [`CHIP_NUM][`DATA_LEN];
    logic [7:0]           exp_q [$];
    string                test_name;
    int                   exp_lat;
    int                   lat_cnt = 0;
    int                   cycles = 0;
    logic                 chk_en;
    logic [`RAM_AW-1:0]   chk_addr;
    logic [7:0]           chk_exp;
    logic                 ignore_window;
    logic [`RAM_AW-1:0]   link_base;
    logic [`RAM_AW-1:0]   type_base;
    logic [`RAM_AW-1:0]   temp_base;
    logic [`RAM_AW-1:0]   data_base0;
    logic [`RAM_AW-1:0]   data_base1;

    tb_clock u_clock (
        .clk (clk),
        .rst (rst)
    );

    acq_frame_top dut (
        .clk        (clk),
        .rst        (rst),
        .fs         (fs),
        .btype      (btype),
        .frame_base (frame_base),
        .cmd        (cmd),
        .stat       (stat),
        .adc_wr     (adc_wr),
        .adc_din    (adc_din),
        .rd_addr    (rd_addr),
        .fd         (fd),
        .rd_data    (rd_data),
        .fifo_full  (fifo_full)
    );

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1);
    endtask

    // Counts every edge that sees fs high.
    always @(posedge clk) begin
        lat_cnt <= fs ? lat_cnt + 1 : 0;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout after %0d cycles in test %s",
                                TIMEOUT_CYCLES, test_name));
        end
    end

    // Readback byte belongs to the address driven one cycle earlier.
    a_readback: assert property (@(posedge clk) chk_en |-> rd_data == chk_exp)
        else abort_run($sformatf("** Error %s addr %h: expected %h, actual %h",
                                 test_name, chk_addr, chk_exp, $sampled(rd_data)));

    a_latency: assert property (
        @(posedge clk) disable iff (rst) $rose(fd) |-> lat_cnt == exp_lat + 1)
        else abort_run($sformatf("** Error %s fd latency: expected %0d, actual %0d",
                                 test_name, exp_lat, $sampled(lat_cnt) - 1));
    a_fd_hold: assert property (@(posedge clk) disable iff (rst) fd && fs |=> fd)
        else abort_run($sformatf("fd dropped in %s while fs was still high", test_name));
    a_fd_drop: assert property (@(posedge clk) disable iff (rst) $fell(fs) |=> !fd)
        else abort_run($sformatf("fd stayed high in %s after fs fell", test_name));
    a_fd_rise: assert property (@(posedge clk) disable iff (rst) $rose(fd) |-> fs)
        else abort_run($sformatf("fd rose in %s without a request", test_name));
    a_ignored: assert property (@(posedge clk) ignore_window |-> !fd)
        else abort_run("fd rose for a request with an unknown packet type");
    a_reset_fd: assert property (@(posedge clk) $fell(rst) |-> !fd)
        else abort_run("fd was high right after reset");
    a_not_full: assert property (@(posedge clk) disable iff (rst) fifo_full == '0)
        else abort_run("a sample FIFO reported full");

    task automatic preload_fifos();
        for (int n = 0; n < `DATA_LEN; n++) begin
            adc_wr = '1;
            for (int c = 0; c < `CHIP_NUM; c++) begin
                samples[c][n] = 8'($urandom);
                adc_din[c] = samples[c][n];
            end
            @(posedge clk);
            #1;
        end
        adc_wr = '0;
    endtask

    // Expected frame bytes from the lowest address up.
    task automatic build_expected(input logic [3:0] code);
        logic [11:0] link_word;
        link_word = `DLINK_WORD;
        exp_q.delete();
        case (code)
            `BAG_DLINK: begin
                exp_q.push_back({`HEAD_DLINK, link_word[11:8]});
                exp_q.push_back(link_word[7:0]);
            end
            `BAG_DTYPE: begin
                exp_q.push_back({`HEAD_DTYPE, cmd.device_idx});
                exp_q.push_back(stat.dev_type);
            end
            `BAG_DTEMP: begin
                exp_q.push_back({`HEAD_DTEMP, cmd.device_idx});
                exp_q.push_back(stat.temp);
            end
            `BAG_DATA0, `BAG_DATA1: begin
                exp_q.push_back({`HEAD_DATA, cmd.device_idx});
                exp_q.push_back({cmd.data_idx, stat.stat});
                for (int c = 0; c < `CHIP_NUM; c++) begin
                    for (int n = 0; n < `DATA_LEN; n++) begin
                        exp_q.push_back(samples[c][n]);
                    end
                end
            end
            default: ;
        endcase
    endtask

    task automatic read_back(input string name, input logic [`RAM_AW-1:0] base);
        int len;
        len = exp_q.size();
        test_name = name;
        for (int i = 0; i <= len; i++) begin
            if (i < len) rd_addr = base + `RAM_AW'(i);
            if (i > 0) begin
                chk_addr = base + `RAM_AW'(i - 1);
                chk_exp = exp_q[i - 1];
                chk_en = 1'b1;
            end
            @(posedge clk);
            #1;
        end
        chk_en = 1'b0;
    endtask

    // Full four-phase exchange on fs and fd.
    task automatic request_frame(input string name, input logic [3:0] code,
                                 input logic [`RAM_AW-1:0] base, input int lat);
        test_name = name;
        exp_lat = lat;
        btype = code;
        frame_base = base;
        fs = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!fd);
        // Hold fs a little longer while fd stays up.
        repeat (3) begin
            @(posedge clk);
            #1;
        end
        fs = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (fd);
    endtask

    initial begin
        void'($urandom(32'hdb2));
        fs = 1'b0;
        btype = '0;
        frame_base = '0;
        cmd = '0;
        stat = '0;
        adc_wr = '0;
        for (int c = 0; c < `CHIP_NUM; c++) begin
            adc_din[c] = '0;
        end
        rd_addr = '0;
        chk_en = 1'b0;
        chk_addr = '0;
        chk_exp = '0;
        ignore_window = 1'b0;
        exp_lat = 0;
        test_name = "reset";

        // Disjoint regions so earlier frames stay readable.
        link_base = `RAM_AW'($urandom_range(0, 255));
        type_base = `RAM_AW'(256 + $urandom_range(0, 255));
        temp_base = `RAM_AW'(512 + $urandom_range(0, 255));
        data_base0 = `RAM_AW'(1024 + $urandom_range(0, 255));
        data_base1 = `RAM_AW'(2048 + $urandom_range(0, 255));

        @(negedge rst);
        @(posedge clk);
        #1;

        cmd = 8'($urandom);
        stat = 20'($urandom);
        request_frame("link_frame", `BAG_DLINK, link_base, SHORT_LAT);
        build_expected(`BAG_DLINK);
        read_back("link_frame", link_base);

        // Temperature request follows right after fd drops.
        request_frame("type_frame", `BAG_DTYPE, type_base, SHORT_LAT);
        request_frame("temp_frame", `BAG_DTEMP, temp_base, SHORT_LAT);
        build_expected(`BAG_DTYPE);
        read_back("type_frame", type_base);
        build_expected(`BAG_DTEMP);
        read_back("temp_frame", temp_base);

        test_name = "unknown_type";
        btype = 4'h3;
        frame_base = link_base;
        ignore_window = 1'b1;
        fs = 1'b1;
        repeat (20) begin
            @(posedge clk);
            #1;
        end
        fs = 1'b0;
        @(posedge clk);
        #1;
        ignore_window = 1'b0;
        build_expected(`BAG_DLINK);
        read_back("unknown_type", link_base);

        preload_fifos();
        cmd = 8'($urandom);
        stat = 20'($urandom);
        request_frame("data_frame0", `BAG_DATA0, data_base0, DATA_LAT);
        build_expected(`BAG_DATA0);
        read_back("data_frame0", data_base0);

        preload_fifos();
        cmd = 8'($urandom);
        stat = 20'($urandom);
        request_frame("data_frame1", `BAG_DATA1, data_base1, DATA_LAT);
        a_drained: assert (dut.fifo_empty == '1)
            else abort_run("sample FIFOs still hold data after data_frame1");
        build_expected(`BAG_DATA1);
        read_back("data_frame1", data_base1);

        $display("all tests passed");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+.
pkt_pkg.sv
sample_fifo.sv
frame_builder.sv
frame_ram.sv
acq_frame_top.sv
tb_clock.sv
tb_acq_frame.sv

// ==== Makefile ====
SRCS = build.f pkt_cfg.svh pkt_pkg.sv sample_fifo.sv frame_builder.sv frame_ram.sv \
       acq_frame_top.sv tb_clock.sv tb_acq_frame.sv

obj_dir/Vtb_acq_frame: $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_acq_frame

run: obj_dir/Vtb_acq_frame
	./obj_dir/Vtb_acq_frame > sim.log 2>&1 || true
	cat sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
